//--- hdl/cpu_pkg.sv
package cpu_pkg;

	localparam int ISSUE_NUM         = 2;
	localparam int DCACHE_PIPE_DEPTH = 2;
	localparam int QUEUE_DEPTH       = 4;

	// operation classes the issue logic cares about
	typedef enum logic [4:0] {
		OP_NOP = 5'd0,
		OP_ALU,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_J,
		OP_MULT,
		OP_DIV,
		OP_MFHI,
		OP_MFLO,
		OP_MTC0,
		OP_MFC0,
		OP_ERET
	} op_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] iaddr;
		logic [31:0] instr;
	} fetch_entry_t;

	typedef struct packed {
		op_t         op;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		// zero when nothing is written
		logic [4:0]  rd;
		logic        is_load;
		logic        is_store;
		logic        is_controlflow;
		logic        is_multicyc;
		logic        is_priv;
		logic        is_nonrw_priv;
		logic [31:0] instr;
	} decoded_instr_t;

endpackage

//--- hdl/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     fetch_req,
	input  logic [31:0]                              fetch_instr0,
	input  logic [31:0]                              fetch_instr1,
	input  logic [31:0]                              fetch_iaddr,
	input  logic [$clog2(cpu_pkg::ISSUE_NUM+1)-1:0]  issue_num,
	input  logic                                     frozen,
	output logic                                     fetch_ack,
	output cpu_pkg::fetch_entry_t                    head_entry0,
	output cpu_pkg::fetch_entry_t                    head_entry1
);
	import cpu_pkg::*;

	typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] count_t;

	fetch_entry_t mem [QUEUE_DEPTH];
	logic [$clog2(QUEUE_DEPTH)-1:0] head;
	logic [$clog2(QUEUE_DEPTH)-1:0] head_next;
	logic [$clog2(QUEUE_DEPTH)-1:0] tail;
	logic [$clog2(QUEUE_DEPTH)-1:0] tail_next;
	count_t count;
	count_t push_num;
	logic [$clog2(ISSUE_NUM+1)-1:0] pop_num;
	logic push;

	assign head_next = head + 1'b1;
	assign tail_next = tail + 1'b1;

	// a pair is only taken when both halves fit
	assign push     = fetch_req & ~fetch_ack & (count <= count_t'(QUEUE_DEPTH - ISSUE_NUM));
	assign push_num = push ? count_t'(ISSUE_NUM) : '0;
	assign pop_num  = frozen ? '0 : issue_num;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[tail]      <= '{valid: 1'b1, iaddr: fetch_iaddr, instr: fetch_instr0};
			mem[tail_next] <= '{valid: 1'b1, iaddr: fetch_iaddr + 32'd4, instr: fetch_instr1};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			fetch_ack <= 1'b0;
		end else begin
			head  <= head + pop_num;
			count <= count + push_num - count_t'(pop_num);
			if (push) begin
				tail <= tail_next + 1'b1;
			end
			// ack stays up until the requester lets go
			if (push) begin
				fetch_ack <= 1'b1;
			end else if (!fetch_req) begin
				fetch_ack <= 1'b0;
			end
		end
	end

	always_comb begin
		head_entry0 = '0;
		head_entry1 = '0;
		if (count != '0) begin
			head_entry0 = mem[head];
		end
		if (count > count_t'(1)) begin
			head_entry1 = mem[head_next];
		end
	end

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  cpu_pkg::fetch_entry_t   entry,
	output cpu_pkg::decoded_instr_t decoded
);
	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;

	assign opcode = entry.instr[31:26];
	assign rs     = entry.instr[25:21];
	assign rt     = entry.instr[20:16];
	assign rd     = entry.instr[15:11];
	assign funct  = entry.instr[5:0];

	always_comb begin
		decoded       = '0;
		decoded.instr = entry.instr;
		decoded.rs1   = rs;
		case (opcode)
			6'h00: begin
				decoded.rs2 = rt;
				case (funct)
					6'h08, 6'h09: begin
						decoded.op             = OP_J;
						decoded.is_controlflow = 1'b1;
					end
					6'h10: begin
						decoded.op = OP_MFHI;
						decoded.rd = rd;
					end
					6'h12: begin
						decoded.op = OP_MFLO;
						decoded.rd = rd;
					end
					// results land in hi/lo, not in the register file
					6'h18, 6'h19: begin
						decoded.op          = OP_MULT;
						decoded.is_multicyc = 1'b1;
					end
					6'h1a, 6'h1b: begin
						decoded.op          = OP_DIV;
						decoded.is_multicyc = 1'b1;
					end
					default: begin
						decoded.op = OP_ALU;
						decoded.rd = rd;
					end
				endcase
			end
			6'h02, 6'h03: begin
				decoded.op             = OP_J;
				decoded.rs1            = '0;
				decoded.is_controlflow = 1'b1;
			end
			6'h04, 6'h05, 6'h06, 6'h07: begin
				decoded.op             = OP_BEQ;
				decoded.rs2            = rt;
				decoded.is_controlflow = 1'b1;
			end
			// immediate alu forms write rt
			6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
				decoded.op = OP_ALU;
				decoded.rd = rt;
			end
			6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
				decoded.op      = OP_LW;
				decoded.rd      = rt;
				decoded.is_load = 1'b1;
			end
			6'h28, 6'h29, 6'h2b: begin
				decoded.op       = OP_SW;
				decoded.rs2      = rt;
				decoded.is_store = 1'b1;
			end
			6'h10: begin
				decoded.rs1     = '0;
				decoded.is_priv = 1'b1;
				case (rs)
					5'h00: begin
						decoded.op = OP_MFC0;
						decoded.rd = rt;
					end
					5'h04: begin
						decoded.op  = OP_MTC0;
						decoded.rs2 = rt;
					end
					// co format, eret and tlb maintenance
					default: begin
						decoded.is_nonrw_priv = 1'b1;
						if (funct == 6'h18) begin
							decoded.op = OP_ERET;
						end
					end
				endcase
			end
			default: begin
				decoded.rs1 = '0;
			end
		endcase
		if (!entry.valid) begin
			decoded = '0;
		end
	end

endmodule

//--- hdl/instr_issue.sv
`timescale 1ns/1ps

// pairing rules assume exactly two slots
module instr_issue (
	input  cpu_pkg::decoded_instr_t                  id_decoded0,
	input  cpu_pkg::decoded_instr_t                  id_decoded1,
	input  logic                                     instr_valid0,
	input  logic                                     instr_valid1,
	input  cpu_pkg::decoded_instr_t                  ex_decoded0,
	input  cpu_pkg::decoded_instr_t                  ex_decoded1,
	input  cpu_pkg::decoded_instr_t                  dc0_decoded0,
	input  cpu_pkg::decoded_instr_t                  dc0_decoded1,
	input  cpu_pkg::decoded_instr_t                  dc1_decoded0,
	input  cpu_pkg::decoded_instr_t                  dc1_decoded1,
	input  logic                                     frozen,
	output logic [$clog2(cpu_pkg::ISSUE_NUM+1)-1:0]  issue_num,
	output cpu_pkg::decoded_instr_t                  issue_instr0,
	output cpu_pkg::decoded_instr_t                  issue_instr1
);
	import cpu_pkg::*;

	function automatic logic is_load_related(
		input decoded_instr_t id,
		input decoded_instr_t older
	);
		return older.is_load && older.rd != '0 &&
			(id.rs1 == older.rd || id.rs2 == older.rd);
	endfunction

	function automatic logic is_data_related(
		input decoded_instr_t first,
		input decoded_instr_t second
	);
		return first.rd != '0 && (second.rs1 == first.rd || second.rs2 == first.rd);
	endfunction

	function automatic logic reads_hilo(
		input decoded_instr_t id
	);
		return id.op == OP_MFHI || id.op == OP_MFLO;
	endfunction

	// loads whose data is not back yet
	decoded_instr_t load_window [2*ISSUE_NUM];
	logic [ISSUE_NUM-1:0] load_hit;
	logic [ISSUE_NUM-1:0] mem_access;
	logic slot1_not_taken;
	logic priv_in_ex;
	logic nonrw_priv_busy;
	logic stall;

	assign load_window = '{ex_decoded0, ex_decoded1, dc0_decoded0, dc0_decoded1};

	assign mem_access[0] = id_decoded0.is_load | id_decoded0.is_store;
	assign mem_access[1] = id_decoded1.is_load | id_decoded1.is_store;

	always_comb begin
		load_hit = '0;
		for (int i = 0; i < 2*ISSUE_NUM; i++) begin
			load_hit[0] |= is_load_related(id_decoded0, load_window[i]);
			load_hit[1] |= is_load_related(id_decoded1, load_window[i]);
		end
		load_hit &= {instr_valid1, instr_valid0};
	end

	assign priv_in_ex = ex_decoded0.is_priv | ex_decoded1.is_priv;

	assign nonrw_priv_busy =
		  ex_decoded0.is_nonrw_priv  | ex_decoded1.is_nonrw_priv
		| dc0_decoded0.is_nonrw_priv | dc0_decoded1.is_nonrw_priv
		| dc1_decoded0.is_nonrw_priv | dc1_decoded1.is_nonrw_priv;

	// a branch always drags its delay slot along
	assign slot1_not_taken = ~id_decoded0.is_controlflow && (
		   ~instr_valid1
		|| is_data_related(id_decoded0, id_decoded1)
		|| (mem_access[0] && mem_access[1])
		|| id_decoded1.is_controlflow
		|| (id_decoded0.is_priv && id_decoded1.is_priv)
		|| (id_decoded0.is_multicyc && id_decoded1.is_multicyc)
		|| (id_decoded0.is_multicyc && reads_hilo(id_decoded1))
		|| id_decoded1.op == OP_ERET
	);

	assign stall =
		  load_hit[0]
		| (load_hit[1] & ~slot1_not_taken)
		| priv_in_ex
		| nonrw_priv_busy
		| (id_decoded0.is_controlflow & ~instr_valid1)
		| ~(instr_valid0 | instr_valid1)
		| frozen;

	always_comb begin
		issue_num    = 2'd2;
		issue_instr0 = id_decoded0;
		issue_instr1 = id_decoded1;
		if (stall) begin
			issue_num    = '0;
			issue_instr0 = '0;
			issue_instr1 = '0;
		end else if (slot1_not_taken) begin
			issue_num    = 2'd1;
			issue_instr1 = '0;
		end
	end

endmodule

//--- hdl/pipe_tracker.sv
`timescale 1ns/1ps

module pipe_tracker (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic [$clog2(cpu_pkg::ISSUE_NUM+1)-1:0]  issue_num,
	input  cpu_pkg::decoded_instr_t                  issue_instr0,
	input  cpu_pkg::decoded_instr_t                  issue_instr1,
	input  logic                                     retire_ack,
	output cpu_pkg::decoded_instr_t                  ex_decoded0,
	output cpu_pkg::decoded_instr_t                  ex_decoded1,
	output cpu_pkg::decoded_instr_t                  dc0_decoded0,
	output cpu_pkg::decoded_instr_t                  dc0_decoded1,
	output cpu_pkg::decoded_instr_t                  dc1_decoded0,
	output cpu_pkg::decoded_instr_t                  dc1_decoded1,
	output logic                                     frozen,
	output logic                                     retire_req,
	output logic [$clog2(cpu_pkg::ISSUE_NUM+1)-1:0]  retire_count,
	output logic [31:0]                              retire_instr0,
	output logic [31:0]                              retire_instr1
);
	import cpu_pkg::*;

	typedef enum logic {
		RS_OFFER,
		RS_ACKED
	} retire_state_t;

	// stage 0 is ex, the rest are dcache stages
	decoded_instr_t stage_instr [DCACHE_PIPE_DEPTH+1][ISSUE_NUM];
	logic [$clog2(ISSUE_NUM+1)-1:0] stage_count [DCACHE_PIPE_DEPTH+1];
	retire_state_t state;
	logic group_ready;
	logic accept;

	assign group_ready = stage_count[DCACHE_PIPE_DEPTH] != '0;
	assign retire_req  = group_ready && state == RS_OFFER;
	assign accept      = retire_req & retire_ack;
	// last stage cannot move until its group is taken
	assign frozen      = group_ready & ~accept;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s <= DCACHE_PIPE_DEPTH; s++) begin
				stage_count[s]    <= '0;
				stage_instr[s][0] <= '0;
				stage_instr[s][1] <= '0;
			end
		end else if (!frozen) begin
			stage_count[0]    <= issue_num;
			stage_instr[0][0] <= issue_instr0;
			stage_instr[0][1] <= issue_instr1;
			for (int s = 1; s <= DCACHE_PIPE_DEPTH; s++) begin
				stage_count[s] <= stage_count[s-1];
				stage_instr[s] <= stage_instr[s-1];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= RS_OFFER;
		end else begin
			case (state)
				RS_OFFER: begin
					if (accept) begin
						state <= RS_ACKED;
					end
				end
				// wait for ack to drop before the next offer
				RS_ACKED: begin
					if (!retire_ack) begin
						state <= RS_OFFER;
					end
				end
				default: begin
					state <= RS_OFFER;
				end
			endcase
		end
	end

	assign ex_decoded0  = stage_instr[0][0];
	assign ex_decoded1  = stage_instr[0][1];
	assign dc0_decoded0 = stage_instr[1][0];
	assign dc0_decoded1 = stage_instr[1][1];
	assign dc1_decoded0 = stage_instr[DCACHE_PIPE_DEPTH][0];
	assign dc1_decoded1 = stage_instr[DCACHE_PIPE_DEPTH][1];

	assign retire_count  = stage_count[DCACHE_PIPE_DEPTH];
	assign retire_instr0 = stage_instr[DCACHE_PIPE_DEPTH][0].instr;
	assign retire_instr1 = stage_instr[DCACHE_PIPE_DEPTH][1].instr;

endmodule

//--- hdl/dual_issue_top.sv
`timescale 1ns/1ps

module dual_issue_top (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     fetch_req,
	input  logic [31:0]                              fetch_instr0,
	input  logic [31:0]                              fetch_instr1,
	input  logic [31:0]                              fetch_iaddr,
	input  logic                                     retire_ack,
	output logic                                     fetch_ack,
	output logic                                     retire_req,
	output logic [$clog2(cpu_pkg::ISSUE_NUM+1)-1:0]  retire_count,
	output logic [31:0]                              retire_instr0,
	output logic [31:0]                              retire_instr1
);
	import cpu_pkg::*;

	fetch_entry_t head_entry0;
	fetch_entry_t head_entry1;
	decoded_instr_t id_decoded0;
	decoded_instr_t id_decoded1;
	decoded_instr_t issue_instr0;
	decoded_instr_t issue_instr1;
	decoded_instr_t ex_decoded0;
	decoded_instr_t ex_decoded1;
	decoded_instr_t dc0_decoded0;
	decoded_instr_t dc0_decoded1;
	decoded_instr_t dc1_decoded0;
	decoded_instr_t dc1_decoded1;
	logic [$clog2(ISSUE_NUM+1)-1:0] issue_num;
	logic frozen;

	fetch_queue i_queue (
		.clk          (clk),
		.arst_n       (arst_n),
		.fetch_req    (fetch_req),
		.fetch_instr0 (fetch_instr0),
		.fetch_instr1 (fetch_instr1),
		.fetch_iaddr  (fetch_iaddr),
		.issue_num    (issue_num),
		.frozen       (frozen),
		.fetch_ack    (fetch_ack),
		.head_entry0  (head_entry0),
		.head_entry1  (head_entry1)
	);

	instr_decoder i_dec0 (
		.entry   (head_entry0),
		.decoded (id_decoded0)
	);

	instr_decoder i_dec1 (
		.entry   (head_entry1),
		.decoded (id_decoded1)
	);

	instr_issue i_issue (
		.id_decoded0  (id_decoded0),
		.id_decoded1  (id_decoded1),
		.instr_valid0 (head_entry0.valid),
		.instr_valid1 (head_entry1.valid),
		.ex_decoded0  (ex_decoded0),
		.ex_decoded1  (ex_decoded1),
		.dc0_decoded0 (dc0_decoded0),
		.dc0_decoded1 (dc0_decoded1),
		.dc1_decoded0 (dc1_decoded0),
		.dc1_decoded1 (dc1_decoded1),
		.frozen       (frozen),
		.issue_num    (issue_num),
		.issue_instr0 (issue_instr0),
		.issue_instr1 (issue_instr1)
	);

	pipe_tracker i_tracker (
		.clk           (clk),
		.arst_n        (arst_n),
		.issue_num     (issue_num),
		.issue_instr0  (issue_instr0),
		.issue_instr1  (issue_instr1),
		.retire_ack    (retire_ack),
		.ex_decoded0   (ex_decoded0),
		.ex_decoded1   (ex_decoded1),
		.dc0_decoded0  (dc0_decoded0),
		.dc0_decoded1  (dc0_decoded1),
		.dc1_decoded0  (dc1_decoded0),
		.dc1_decoded1  (dc1_decoded1),
		.frozen        (frozen),
		.retire_req    (retire_req),
		.retire_count  (retire_count),
		.retire_instr0 (retire_instr0),
		.retire_instr1 (retire_instr1)
	);

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reset held for four clock periods
	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

//--- test/tb_dual_issue.sv
`timescale 1ns/1ps

module tb_dual_issue;

	localparam int TIMEOUT_CYCLES = 300;
	localparam int VEC_WORDS      = 256;
	// bit positions of the instruction class vector
	localparam int C_MEM    = 0;
	localparam int C_BRANCH = 1;
	localparam int C_PRIV   = 2;
	localparam int C_MULTI  = 3;
	localparam int C_HILO   = 4;
	localparam int C_ERET   = 5;

	logic        clk;
	logic        arst_n;
	logic        fetch_req;
	logic [31:0] fetch_instr0;
	logic [31:0] fetch_instr1;
	logic [31:0] fetch_iaddr;
	logic        retire_ack;
	logic        fetch_ack;
	logic        retire_req;
	logic [1:0]  retire_count;
	logic [31:0] retire_instr0;
	logic [31:0] retire_instr1;

	logic [31:0] vec [VEC_WORDS];
	logic [31:0] program_q [$];
	int          sizes_q [$];
	int          vec_pos;
	int          num_tests;
	int          t;
	int          n;
	int          errors;
	int          tests_passed;
	int          tests_failed;
	int          group_total;
	logic        timed_out;
	logic [31:0] lcg_state;

	tb_clock_gen i_clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	dual_issue_top i_dut (
		.clk           (clk),
		.arst_n        (arst_n),
		.fetch_req     (fetch_req),
		.fetch_instr0  (fetch_instr0),
		.fetch_instr1  (fetch_instr1),
		.fetch_iaddr   (fetch_iaddr),
		.retire_ack    (retire_ack),
		.fetch_ack     (fetch_ack),
		.retire_req    (retire_req),
		.retire_count  (retire_count),
		.retire_instr0 (retire_instr0),
		.retire_instr1 (retire_instr1)
	);

	function automatic int next_delay();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {30'd0, lcg_state[17:16]};
	endfunction

	// instruction classes straight from the mips encoding
	function automatic logic [5:0] classify(input logic [31:0] w);
		logic [5:0] c;
		c = '0;
		case (w[31:26])
			6'h00: begin
				case (w[5:0])
					6'h08, 6'h09: c[C_BRANCH] = 1'b1;
					6'h10, 6'h12: c[C_HILO] = 1'b1;
					6'h18, 6'h19, 6'h1a, 6'h1b: c[C_MULTI] = 1'b1;
					default: ;
				endcase
			end
			6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07: c[C_BRANCH] = 1'b1;
			6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b: c[C_MEM] = 1'b1;
			6'h10: begin
				c[C_PRIV] = 1'b1;
				c[C_ERET] = (w == 32'h42000018);
			end
			default: ;
		endcase
		return c;
	endfunction

	function automatic logic [4:0] dest_reg(input logic [31:0] w);
		logic [5:0] c;
		logic [4:0] d;
		c = classify(w);
		d = '0;
		case (w[31:26])
			6'h00: begin
				if (!c[C_BRANCH] && !c[C_MULTI]) begin
					d = w[15:11];
				end
			end
			6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: d = w[20:16];
			6'h20, 6'h21, 6'h23, 6'h24, 6'h25: d = w[20:16];
			// mfc0 writes rt
			6'h10: begin
				if (w[25:21] == 5'h00) begin
					d = w[20:16];
				end
			end
			default: ;
		endcase
		return d;
	endfunction

	function automatic logic reads_reg(input logic [31:0] w, input logic [4:0] r);
		logic use_rs;
		logic use_rt;
		use_rs = 1'b0;
		use_rt = 1'b0;
		case (w[31:26])
			6'h00, 6'h04, 6'h05, 6'h06, 6'h07, 6'h28, 6'h29, 6'h2b: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
			end
			6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: use_rs = 1'b1;
			6'h20, 6'h21, 6'h23, 6'h24, 6'h25: use_rs = 1'b1;
			6'h10: use_rt = (w[25:21] == 5'h04);
			default: ;
		endcase
		return r != 5'd0 && ((use_rs && w[25:21] == r) || (use_rt && w[20:16] == r));
	endfunction

	function automatic logic pair_allowed(input logic [31:0] w0, input logic [31:0] w1);
		logic [5:0] c0;
		logic [5:0] c1;
		c0 = classify(w0);
		c1 = classify(w1);
		if (c0[C_BRANCH]) begin
			return 1'b1;
		end
		return !(reads_reg(w1, dest_reg(w0))
			|| (c0[C_MEM] && c1[C_MEM])
			|| c1[C_BRANCH]
			|| (c0[C_PRIV] && c1[C_PRIV])
			|| (c0[C_MULTI] && c1[C_MULTI])
			|| (c0[C_MULTI] && c1[C_HILO])
			|| c1[C_ERET]);
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
		errors++;
	endtask

	task automatic report_error(input string msg);
		$display("error: %s", msg);
		errors++;
	endtask

	task automatic report_timeout(input string msg);
		$display("timeout: %s", msg);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic wait_fetch_ack(input logic level, output logic ok);
		int k;
		ok = 1'b0;
		for (k = 0; k < TIMEOUT_CYCLES && !ok; k++) begin
			@(negedge clk);
			ok = (fetch_ack === level);
		end
	endtask

	task automatic wait_retire_req(input logic level, output logic ok);
		int k;
		ok = 1'b0;
		for (k = 0; k < TIMEOUT_CYCLES && !ok; k++) begin
			@(negedge clk);
			ok = (retire_req === level);
		end
	endtask

	task automatic feed_pair(input logic [31:0] w0, input logic [31:0] w1, input logic [31:0] addr);
		logic ok;
		@(negedge clk);
		fetch_req    = 1'b1;
		fetch_instr0 = w0;
		fetch_instr1 = w1;
		fetch_iaddr  = addr;
		wait_fetch_ack(1'b1, ok);
		fetch_req = 1'b0;
		if (!ok) begin
			report_timeout("fetch_ack never rose for a requested pair");
		end else begin
			wait_fetch_ack(1'b0, ok);
			if (!ok) begin
				report_timeout("fetch_ack stayed high after fetch_req dropped");
			end
		end
	endtask

	task automatic check_retire_hold(input logic [1:0] cnt, input logic [31:0] w0,
		input logic [31:0] w1);
		if (retire_req !== 1'b1) begin
			report_value("retire_req", 32'd1, retire_req);
		end
		if (retire_count !== cnt) begin
			report_value("retire_count", cnt, retire_count);
		end
		if (retire_instr0 !== w0) begin
			report_value("retire_instr0", w0, retire_instr0);
		end
		if (retire_instr1 !== w1) begin
			report_value("retire_instr1", w1, retire_instr1);
		end
	endtask

	task automatic check_word(input int pos, input string name, input logic [31:0] act);
		if (pos >= program_q.size()) begin
			report_error("more words retired than were fetched");
		end else if (act !== program_q[pos]) begin
			report_value(name, program_q[pos], act);
		end
	endtask

	task automatic check_group(input int pos, input logic [1:0] cnt, input logic [31:0] w0,
		input logic [31:0] w1);
		logic [5:0] c0;
		logic [5:0] c1;
		c0 = classify(w0);
		c1 = classify(w1);
		if (cnt == 2'd0 || cnt == 2'd3) begin
			report_error($sformatf("retire_req raised with group size %0d", cnt));
		end
		if (group_total < sizes_q.size() && sizes_q[group_total] != cnt) begin
			report_value("retire_count", sizes_q[group_total], cnt);
		end
		check_word(pos, "retire_instr0", w0);
		if (cnt == 2'd2) begin
			check_word(pos + 1, "retire_instr1", w1);
			if (c1[C_BRANCH]) begin
				report_error("branch retired in slot 1");
			end
			if (!pair_allowed(w0, w1)) begin
				report_error($sformatf("illegal pair %08h %08h retired together", w0, w1));
			end
		end else if (cnt == 2'd1) begin
			if (w1 !== 32'd0) begin
				report_value("retire_instr1", 32'd0, w1);
			end
			if (c0[C_BRANCH]) begin
				report_error("branch retired without its delay slot");
			end
		end
	endtask

	// answers every retire request and checks each group against the program
	task automatic collect_groups();
		logic ok;
		logic [1:0] cnt_h;
		logic [31:0] w0_h;
		logic [31:0] w1_h;
		int pos;
		int delay;
		int d;
		pos = 0;
		while (pos < program_q.size() && !timed_out) begin
			wait_retire_req(1'b1, ok);
			if (!ok) begin
				report_timeout("no group retired while fetched words were outstanding");
			end else begin
				cnt_h = retire_count;
				w0_h  = retire_instr0;
				w1_h  = retire_instr1;
				check_group(pos, cnt_h, w0_h, w1_h);
				pos += (cnt_h == 2'd0) ? 1 : int'(cnt_h);
				group_total++;
				delay = next_delay();
				for (d = 0; d < delay; d++) begin
					@(negedge clk);
					check_retire_hold(cnt_h, w0_h, w1_h);
				end
				retire_ack = 1'b1;
				wait_retire_req(1'b0, ok);
				retire_ack = 1'b0;
				if (!ok) begin
					report_timeout("retire_req stayed high after retire_ack");
				end
			end
		end
		if (!timed_out && sizes_q.size() != 0 && group_total != sizes_q.size()) begin
			report_error($sformatf("%0d groups retired, %0d expected",
				group_total, sizes_q.size()));
		end
	endtask

	task automatic run_stream();
		int p;
		fork
			begin
				for (p = 0; p + 1 < program_q.size(); p += 2) begin
					if (!timed_out) begin
						feed_pair(program_q[p], program_q[p+1], 32'h1000 + 32'(4 * p));
					end
				end
			end
			collect_groups();
		join
	endtask

	task automatic run_preload();
		logic ok;
		logic [1:0] cnt_h;
		logic [31:0] w0_h;
		logic [31:0] w1_h;
		int k;
		// a nop pair parks in dc1 while ack is withheld, so the test words wait in the queue
		program_q.push_front(32'd0);
		program_q.push_front(32'd0);
		sizes_q.push_front(2);
		feed_pair(32'd0, 32'd0, 32'h2000);
		if (!timed_out) begin
			wait_retire_req(1'b1, ok);
			if (!ok) begin
				report_timeout("nop pair never reached the retire port");
			end
		end
		if (!timed_out) begin
			feed_pair(program_q[2], program_q[3], 32'h2008);
		end
		if (!timed_out) begin
			feed_pair(program_q[4], program_q[5], 32'h2010);
		end
		if (!timed_out) begin
			cnt_h = retire_count;
			w0_h  = retire_instr0;
			w1_h  = retire_instr1;
			@(negedge clk);
			fetch_req    = 1'b1;
			fetch_instr0 = 32'h24e70001;
			fetch_instr1 = 32'h00a62021;
			fetch_iaddr  = 32'h2018;
			// queue is full, so this request must sit unanswered
			for (k = 0; k < 8; k++) begin
				@(negedge clk);
				if (fetch_ack !== 1'b0) begin
					report_value("fetch_ack", 32'd0, fetch_ack);
				end
				check_retire_hold(cnt_h, w0_h, w1_h);
			end
			fetch_req = 1'b0;
			collect_groups();
		end
	endtask

	task automatic run_test(input int idx);
		int mode;
		int nwords;
		int ngroups;
		int err_before;
		int k;
		mode   = vec[vec_pos];
		nwords = vec[vec_pos+1];
		vec_pos += 2;
		program_q.delete();
		sizes_q.delete();
		group_total = 0;
		for (k = 0; k < nwords; k++) begin
			program_q.push_back(vec[vec_pos+k]);
		end
		vec_pos += nwords;
		if (mode == 1) begin
			ngroups = vec[vec_pos];
			vec_pos++;
			for (k = 0; k < ngroups; k++) begin
				sizes_q.push_back(vec[vec_pos+k]);
			end
			vec_pos += ngroups;
		end
		err_before = errors;
		if (mode == 1) begin
			run_preload();
		end else begin
			run_stream();
		end
		if (errors == err_before) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("test %0d %s: %s, %0d words in %0d groups", idx,
			(mode == 1) ? "preloaded" : "streaming",
			(errors == err_before) ? "passed" : "failed", nwords, group_total);
	endtask

	initial begin
		fetch_req    = 1'b0;
		fetch_instr0 = '0;
		fetch_instr1 = '0;
		fetch_iaddr  = '0;
		retire_ack   = 1'b0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		group_total  = 0;
		timed_out    = 1'b0;
		lcg_state    = 32'd73919;
		$readmemh("test/issue_vectors.txt", vec);

		for (n = 0; n < 20 && arst_n !== 1'b1; n++) begin
			@(negedge clk);
		end
		if (arst_n !== 1'b1) begin
			report_timeout("reset was never released");
		end

		// idle after reset
		if (!timed_out) begin
			t = errors;
			for (n = 0; n < 10; n++) begin
				@(negedge clk);
				if (fetch_ack !== 1'b0) begin
					report_value("fetch_ack", 32'd0, fetch_ack);
				end
				if (retire_req !== 1'b0) begin
					report_value("retire_req", 32'd0, retire_req);
				end
			end
			if (errors == t) begin
				tests_passed++;
			end else begin
				tests_failed++;
			end
			$display("test 0 reset idle: %s", (errors == t) ? "passed" : "failed");
		end

		num_tests = vec[0];
		vec_pos   = 1;
		for (t = 1; t <= num_tests && !timed_out; t++) begin
			run_test(t);
		end

		$display("tests passed %0d, tests failed %0d, failed checks %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- dual_issue.f
hdl/cpu_pkg.sv
hdl/fetch_queue.sv
hdl/instr_decoder.sv
hdl/instr_issue.sv
hdl/pipe_tracker.sv
hdl/dual_issue_top.sv
test/tb_clock_gen.sv
test/tb_dual_issue.sv

//--- test/issue_vectors.txt
// number of tests, then per test: mode (0 streaming, 1 preloaded), word count, words
// preloaded tests add a group count and the expected group sizes
8
// streaming with load-use, store, branch and multiply
0 8
8c280000 01015021 24e70001 ac440008
10220004 00a62021 00220018 00003010
// streaming privileged sequence with eret
0 8
40846000 40026000 00221821 42000018
08000010 00000000 00612821 00003812
// streaming loads around a jump with a load in its delay slot
0 a
8c490004 8c280000 00221821 00612821 08000010
8c490004 01015021 00220018 00003812 00000000
// preloaded legal pairs
1 4
00221821 00a62021 24e70001 8c490004
2 2 2
// preloaded dependent chain
1 4
00221821 00612821 00a62021 00000000
3 1 1 2
// preloaded memory ops, last pair also waits on a load
1 4
8c280000 ac440008 8c490004 01015021
3 1 1 2
// preloaded multiply then mfhi
1 4
00220018 00003010 00003812 00a62021
3 1 2 1
// preloaded branch with its delay slot
1 4
00221821 10220004 00a62021 24e70001
3 1 2 1
